//--- app_cmd_issue.sv
`default_nettype none

module app_cmd_issue
    import ddr_bridge_cfg_pkg::*;
    import ddr_bridge_cmd_pkg::*;
(
    input  wire             clk_if,
    input  wire             resetn,

    input  wire line_cmd_t  line_cmd,
    input  wire             line_valid,
    output logic            line_take,

    output app_req_t        app_req,
    input  wire             app_rdy,
    output app_wdf_t        app_wdf,
    input  wire             app_wdf_rdy,
    input  wire app_rd_t    app_rd,

    input  wire             resp_space,
    output logic            ret_push,
    output rd_resp_t        ret_data
);

    issue_state_t state;
    issue_state_t state_next;

    logic     wr_go;
    logic     rd_go;

    // application side registers
    logic     req_en;
    app_cmd_t req_cmd;
    addr_t    req_addr;
    logic     wr_pulse;
    data_t    wdf_data;
    strb_t    wdf_mask;

    // id and last of the read in flight
    id_t      rd_id;
    logic     rd_last;

    assign wr_go = line_valid && !line_cmd.rd && app_rdy && app_wdf_rdy;
    // queue space is checked here so the later push always fits
    assign rd_go = line_valid && line_cmd.rd && app_rdy && resp_space;

    always_comb begin
        state_next = state;
        line_take  = 1'b0;
        ret_push   = 1'b0;
        case (state)
            ISSUE_IDLE: begin
                if (wr_go || rd_go) begin
                    line_take = 1'b1;
                    if (rd_go) begin
                        state_next = ISSUE_RD_WAIT;
                    end
                end
            end
            ISSUE_RD_WAIT: begin
                if (app_rd.valid) begin
                    ret_push   = 1'b1;
                    state_next = ISSUE_IDLE;
                end
            end
            default: state_next = ISSUE_IDLE;
        endcase
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            state    <= ISSUE_IDLE;
            req_en   <= 1'b0;
            wr_pulse <= 1'b0;
        end else begin
            state    <= state_next;
            req_en   <= line_take;
            wr_pulse <= line_take && !line_cmd.rd;
        end
    end

    always_ff @(posedge clk_if) begin
        if (line_take) begin
            req_cmd  <= line_cmd.rd ? APP_CMD_READ : APP_CMD_WRITE;
            req_addr <= line_cmd.addr;
            rd_id    <= line_cmd.id;
            rd_last  <= line_cmd.last;
            if (!line_cmd.rd) begin
                wdf_data <= line_cmd.data;
                wdf_mask <= line_cmd.mask;
            end
        end
    end

    always_comb begin
        app_req.en       = req_en;
        app_req.cmd      = req_cmd;
        app_req.addr     = req_addr;
        app_wdf.wren     = wr_pulse;
        app_wdf.data_end = wr_pulse;
        app_wdf.data     = wdf_data;
        app_wdf.mask     = wdf_mask;
    end

    // returned line goes out unshifted
    always_comb begin
        ret_data.id   = rd_id;
        ret_data.data = app_rd.data;
        ret_data.last = rd_last;
    end

endmodule

`default_nettype wire

//--- ddr_app_bridge.sv
`default_nettype none

module ddr_app_bridge
    import ddr_bridge_cmd_pkg::*;
#(
    parameter int RESP_DEPTH = 4
)
(
    input  wire             clk_if,
    input  wire             resetn,

    // RAM command port
    input  wire ram_cmd_t   cmd,
    input  wire             cmd_valid,
    output logic            cmd_ready,

    // DDR controller application port
    output app_req_t        app_req,
    input  wire             app_rdy,
    output app_wdf_t        app_wdf,
    input  wire             app_wdf_rdy,
    input  wire app_rd_t    app_rd,

    // read responses
    output rd_resp_t        rd_resp,
    output logic            rd_resp_valid,
    input  wire             rd_resp_ready
);

    line_cmd_t line_cmd;
    logic      line_valid;
    logic      line_take;
    logic      resp_space;
    logic      ret_push;
    rd_resp_t  ret_data;

    ram_cmd_decode u_decode (
        .clk_if     (clk_if),
        .resetn     (resetn),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .line_cmd   (line_cmd),
        .line_valid (line_valid),
        .line_take  (line_take)
    );

    app_cmd_issue u_issue (
        .clk_if      (clk_if),
        .resetn      (resetn),
        .line_cmd    (line_cmd),
        .line_valid  (line_valid),
        .line_take   (line_take),
        .app_req     (app_req),
        .app_rdy     (app_rdy),
        .app_wdf     (app_wdf),
        .app_wdf_rdy (app_wdf_rdy),
        .app_rd      (app_rd),
        .resp_space  (resp_space),
        .ret_push    (ret_push),
        .ret_data    (ret_data)
    );

    rd_resp_return #(
        .RESP_DEPTH (RESP_DEPTH)
    ) u_return (
        .clk_if        (clk_if),
        .resetn        (resetn),
        .ret_push      (ret_push),
        .ret_data      (ret_data),
        .resp_space    (resp_space),
        .rd_resp       (rd_resp),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_ready (rd_resp_ready)
    );

endmodule

`default_nettype wire

//--- ddr_bridge_cfg_pkg.sv
`default_nettype none

package ddr_bridge_cfg_pkg;

    // one application line, 16 bytes
    localparam int DATA_WIDTH = 128;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // byte address as seen on the app port
    localparam int ADDR_WIDTH = 29;

    localparam int ID_WIDTH = 4;

    // low address bits that select a byte inside a line
    localparam int OFFSET_WIDTH = $clog2(STRB_WIDTH);

    // line payload
    typedef logic [DATA_WIDTH-1:0] data_t;

    // byte strobe, or the inverted write mask
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // transaction id of the RAM command
    typedef logic [ID_WIDTH-1:0] id_t;

    // byte position within a line
    typedef logic [OFFSET_WIDTH-1:0] offset_t;

endpackage

`default_nettype wire

//--- ddr_bridge_cmd_pkg.sv
`default_nettype none

package ddr_bridge_cmd_pkg;

    import ddr_bridge_cfg_pkg::*;

    typedef logic [2:0] app_cmd_t;

    localparam app_cmd_t APP_CMD_WRITE = 3'b000;
    localparam app_cmd_t APP_CMD_READ  = 3'b001;

    // command as it arrives on the RAM port
    typedef struct packed {
        logic  rd;
        logic  last;
        id_t   id;
        addr_t addr;
        data_t data;
        strb_t strb;
    } ram_cmd_t;

    // after decode: aligned address, data and mask already placed in the line
    typedef struct packed {
        logic  rd;
        logic  last;
        id_t   id;
        addr_t addr;
        data_t data;
        strb_t mask;
    } line_cmd_t;

    typedef struct packed {
        logic     en;
        app_cmd_t cmd;
        addr_t    addr;
    } app_req_t;

    // mask bit high means the byte is not written
    typedef struct packed {
        logic  wren;
        logic  data_end;
        data_t data;
        strb_t mask;
    } app_wdf_t;

    typedef struct packed {
        logic  valid;
        logic  data_end;
        data_t data;
    } app_rd_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        logic  last;
    } rd_resp_t;

    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_RD_WAIT
    } issue_state_t;

endpackage

`default_nettype wire

//--- project.f
ddr_bridge_cfg_pkg.sv
ddr_bridge_cmd_pkg.sv
ram_cmd_decode.sv
app_cmd_issue.sv
rd_resp_return.sv
ddr_app_bridge.sv
tb_app_mem_model.sv
tb_ddr_app_bridge.sv

//--- ram_cmd_decode.sv
`default_nettype none

module ram_cmd_decode
    import ddr_bridge_cfg_pkg::*;
    import ddr_bridge_cmd_pkg::*;
(
    input  wire            clk_if,
    input  wire            resetn,

    input  wire ram_cmd_t  cmd,
    input  wire            cmd_valid,
    output logic           cmd_ready,

    output line_cmd_t      line_cmd,
    output logic           line_valid,
    input  wire            line_take
);

    offset_t   offset;
    addr_t     aligned_addr;
    line_cmd_t next_line;
    logic      accept;
    logic      full;
    logic      full_next;

    assign offset       = cmd.addr[OFFSET_WIDTH-1:0];
    assign aligned_addr = {cmd.addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign accept       = cmd_valid && cmd_ready;

    // place write bytes at their offset inside the line
    always_comb begin
        next_line.rd   = cmd.rd;
        next_line.last = cmd.last;
        next_line.id   = cmd.id;
        next_line.addr = aligned_addr;
        if (cmd.rd) begin
            next_line.data = '0;
            next_line.mask = '0;
        end else begin
            next_line.data = cmd.data << {offset, 3'b000};
            // app port wants a mask, active high means keep
            next_line.mask = ~(cmd.strb << offset);
        end
    end

    // take and accept never coincide, ready is low while full
    always_comb begin
        full_next = full;
        if (accept) begin
            full_next = 1'b1;
        end else if (line_take) begin
            full_next = 1'b0;
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            full      <= 1'b0;
            cmd_ready <= 1'b0;
        end else begin
            full      <= full_next;
            cmd_ready <= !full_next;
        end
    end

    always_ff @(posedge clk_if) begin
        if (accept) begin
            line_cmd <= next_line;
        end
    end

    assign line_valid = full;

endmodule

`default_nettype wire

//--- rd_resp_return.sv
`default_nettype none

module rd_resp_return
    import ddr_bridge_cmd_pkg::*;
#(
    parameter int RESP_DEPTH = 4
)
(
    input  wire             clk_if,
    input  wire             resetn,

    input  wire             ret_push,
    input  wire rd_resp_t   ret_data,
    output logic            resp_space,

    output rd_resp_t        rd_resp,
    output logic            rd_resp_valid,
    input  wire             rd_resp_ready
);

    localparam int PTR_WIDTH = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(RESP_DEPTH + 1);

    typedef logic [PTR_WIDTH-1:0] ptr_t;
    typedef logic [CNT_WIDTH-1:0] cnt_t;

    rd_resp_t mem [RESP_DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    cnt_t     count;
    logic     pop;

    assign pop           = rd_resp_valid && rd_resp_ready;
    assign rd_resp_valid = (count != '0);
    assign resp_space    = (count < cnt_t'(RESP_DEPTH));
    assign rd_resp       = mem[rd_ptr];

    always_ff @(posedge clk_if) begin
        if (ret_push) begin
            mem[wr_ptr] <= ret_data;
        end
    end

    // pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (ret_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (ret_push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !ret_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal \
        --top-module tb_ddr_app_bridge -f project.f \
    && ./obj_dir/Vtb_ddr_app_bridge \
    || { echo "simulation failed"; exit 1; }

//--- tb_app_mem_model.sv
`default_nettype none

module tb_app_mem_model
    import ddr_bridge_cfg_pkg::*;
    import ddr_bridge_cmd_pkg::*;
#(
    parameter int          LINES = 16,
    parameter logic [31:0] SEED  = 32'h87ee_436e
)
(
    input  wire           clk_if,
    input  wire           resetn,
    input  wire app_req_t app_req,
    output logic          app_rdy,
    input  wire app_wdf_t app_wdf,
    output logic          app_wdf_rdy,
    output app_rd_t       app_rd
);

    localparam int IDX_W = $clog2(LINES);

    data_t       mem [LINES];
    logic [31:0] lfsr;
    int          cycle;

    // read lines waiting to be returned, oldest first
    data_t       rd_line_q [$];
    int          rd_due_q [$];

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = galois_step(lfsr);
        return b;
    endfunction

    // power-up content, a function of the byte address
    function automatic logic [7:0] fill_byte(input int byte_addr);
        return 8'(byte_addr * 37 + 27);
    endfunction

    initial begin
        lfsr        = SEED;
        cycle       = 0;
        app_rdy     = 1'b0;
        app_wdf_rdy = 1'b0;
        app_rd      = '0;
        for (int a = 0; a < LINES; a++) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                mem[a][b*8 +: 8] = fill_byte(a * STRB_WIDTH + b);
            end
        end
    end

    always @(posedge clk_if) begin
        int   idx;
        int   delay;
        logic r0;
        logic r1;
        cycle = cycle + 1;
        if (resetn && app_req.en) begin
            idx = int'(app_req.addr[OFFSET_WIDTH +: IDX_W]);
            if (app_req.cmd == APP_CMD_WRITE && app_wdf.wren) begin
                // mask bit low means the byte is written
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (!app_wdf.mask[b]) begin
                        mem[idx][b*8 +: 8] = app_wdf.data[b*8 +: 8];
                    end
                end
            end else if (app_req.cmd == APP_CMD_READ) begin
                delay = 2;
                if (take_bit()) begin
                    delay = delay + 1;
                end
                if (take_bit()) begin
                    delay = delay + 2;
                end
                rd_line_q.push_back(mem[idx]);
                rd_due_q.push_back(cycle + delay);
            end
        end
        #1;
        app_rd = '0;
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
            app_rd.valid    = 1'b1;
            app_rd.data_end = 1'b1;
            app_rd.data     = rd_line_q.pop_front();
            void'(rd_due_q.pop_front());
        end
        if (resetn) begin
            // stalls about one cycle in four
            r0          = take_bit();
            r1          = take_bit();
            app_rdy     = r0 | r1;
            app_wdf_rdy = 1'b1;
        end else begin
            app_rdy     = 1'b0;
            app_wdf_rdy = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tb_ddr_app_bridge.sv
`default_nettype none

module tb_ddr_app_bridge
    import ddr_bridge_cfg_pkg::*;
    import ddr_bridge_cmd_pkg::*;
();

    localparam int RESP_DEPTH  = 4;
    localparam int LINES       = 16;
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;

    logic     clk_if;
    logic     resetn;
    ram_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    app_req_t app_req;
    logic     app_rdy;
    app_wdf_t app_wdf;
    logic     app_wdf_rdy;
    app_rd_t  app_rd;
    rd_resp_t rd_resp;
    logic     rd_resp_valid;
    logic     rd_resp_ready;

    // shadow copy of the memory behind the app port
    data_t       shadow [LINES];
    logic [31:0] lfsr_stim;
    logic [31:0] lfsr_ready;
    logic        hold_ready;
    logic        any_cmd;
    logic        rdy_prev;

    // expected app commands and read responses, in command order
    line_cmd_t   app_exp_q [$];
    rd_resp_t    resp_exp_q [$];

    ddr_app_bridge #(
        .RESP_DEPTH (RESP_DEPTH)
    ) DUT (
        .clk_if        (clk_if),
        .resetn        (resetn),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .app_req       (app_req),
        .app_rdy       (app_rdy),
        .app_wdf       (app_wdf),
        .app_wdf_rdy   (app_wdf_rdy),
        .app_rd        (app_rd),
        .rd_resp       (rd_resp),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_ready (rd_resp_ready)
    );

    tb_app_mem_model #(
        .LINES (LINES)
    ) mem_model (
        .clk_if      (clk_if),
        .resetn      (resetn),
        .app_req     (app_req),
        .app_rdy     (app_rdy),
        .app_wdf     (app_wdf),
        .app_wdf_rdy (app_wdf_rdy),
        .app_rd      (app_rd)
    );

    initial begin
        clk_if = 1'b0;
        forever #5 clk_if = ~clk_if;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i]      = lfsr_stim[0];
            lfsr_stim = galois_step(lfsr_stim);
        end
        return v;
    endfunction

    // data and mask as the app port should see them for a write
    function automatic void place_write(input ram_cmd_t c, output data_t d, output strb_t m);
        int off;
        off = int'(c.addr[OFFSET_WIDTH-1:0]);
        d   = '0;
        m   = '1;
        for (int b = off; b < STRB_WIDTH; b++) begin
            d[b*8 +: 8] = c.data[(b-off)*8 +: 8];
            m[b]        = !c.strb[b-off];
        end
    endfunction

    // applies a write to the shadow, returns the line after the command
    function automatic data_t ref_line(input ram_cmd_t c);
        int    idx;
        data_t d;
        strb_t m;
        idx = int'(c.addr[OFFSET_WIDTH +: $clog2(LINES)]);
        if (!c.rd) begin
            place_write(c, d, m);
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (!m[b]) begin
                    shadow[idx][b*8 +: 8] = d[b*8 +: 8];
                end
            end
        end
        return shadow[idx];
    endfunction

    function automatic ram_cmd_t random_cmd(input logic rd);
        ram_cmd_t c;
        c.rd   = rd;
        c.last = 1'(rand_bits(1));
        c.id   = id_t'(rand_bits(ID_WIDTH));
        c.addr = addr_t'(rand_bits(8));
        c.data = data_t'(rand_bits(DATA_WIDTH));
        c.strb = strb_t'(rand_bits(STRB_WIDTH));
        return c;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("Error at %0t: %s is %h, expected %h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic idle(input int cycles);
        if (cycles > 0) begin
            repeat (cycles) @(posedge clk_if);
            #1;
        end
    endtask

    task automatic send_cmd(input ram_cmd_t c);
        line_cmd_t e;
        rd_resp_t  r;
        bit        done;
        cmd       = c;
        cmd_valid = 1'b1;
        done      = 1'b0;
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(posedge clk_if);
            if (cmd_ready) begin
                done = 1'b1;
                break;
            end
        end
        #1;
        if (!done) begin
            stop_on_error("timeout: command was never accepted on cmd_ready");
        end
        e.rd   = c.rd;
        e.last = c.last;
        e.id   = c.id;
        e.addr = c.addr & ~addr_t'(STRB_WIDTH - 1);
        e.data = '0;
        e.mask = '0;
        if (c.rd) begin
            r.id       = c.id;
            r.last     = c.last;
            r.data     = ref_line(c);
            resp_exp_q.push_back(r);
        end else begin
            place_write(c, e.data, e.mask);
            void'(ref_line(c));
        end
        app_exp_q.push_back(e);
        cmd_valid = 1'b0;
        any_cmd   = 1'b1;
    endtask

    task automatic wait_drain();
        bit done;
        done = 1'b0;
        for (int i = 0; i < DRAIN_LIMIT; i++) begin
            @(posedge clk_if);
            #1;
            if (app_exp_q.size() == 0 && resp_exp_q.size() == 0) begin
                done = 1'b1;
                break;
            end
        end
        if (!done) begin
            stop_on_error("timeout: outstanding commands or responses did not drain");
        end
    endtask

    task automatic wait_ready_held_low(input int cycles);
        int low_run;
        bit done;
        low_run = 0;
        done    = 1'b0;
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(posedge clk_if);
            low_run = cmd_ready ? 0 : low_run + 1;
            if (low_run == cycles) begin
                done = 1'b1;
                break;
            end
        end
        #1;
        if (!done) begin
            stop_on_error("timeout: cmd_ready never stayed low while responses were held");
        end
    endtask

    task automatic check_app_cmd();
        line_cmd_t e;
        if (app_exp_q.size() == 0) begin
            stop_on_error("app_req.en pulsed with no command outstanding");
        end
        e = app_exp_q.pop_front();
        // en is registered, so app_rdy is checked in the issuing cycle
        check_value("app_rdy at issue", rdy_prev, 1'b1);
        check_value("app_req.addr offset", app_req.addr[OFFSET_WIDTH-1:0], '0);
        check_value("app_req.addr", app_req.addr, e.addr);
        check_value("app_req.cmd", app_req.cmd, e.rd ? APP_CMD_READ : APP_CMD_WRITE);
        check_value("app_wdf.wren", app_wdf.wren, !e.rd);
        check_value("app_wdf.data_end", app_wdf.data_end, !e.rd);
        if (!e.rd) begin
            check_value("app_wdf.data", app_wdf.data, e.data);
            check_value("app_wdf.mask", app_wdf.mask, e.mask);
        end
    endtask

    task automatic check_resp();
        rd_resp_t e;
        if (resp_exp_q.size() == 0) begin
            stop_on_error("read response arrived with no read outstanding");
        end
        e = resp_exp_q.pop_front();
        check_value("rd_resp.id", rd_resp.id, e.id);
        check_value("rd_resp.last", rd_resp.last, e.last);
        check_value("rd_resp.data", rd_resp.data, e.data);
    endtask

    // compare process, samples at the rising edge
    always @(posedge clk_if) begin
        if (resetn) begin
            if (!any_cmd) begin
                check_value("app_req.en", app_req.en, 1'b0);
                check_value("app_wdf.wren", app_wdf.wren, 1'b0);
                check_value("rd_resp_valid", rd_resp_valid, 1'b0);
            end
            if (app_req.en) begin
                check_app_cmd();
            end else begin
                check_value("app_wdf.wren", app_wdf.wren, 1'b0);
            end
            if (rd_resp_valid && rd_resp_ready) begin
                check_resp();
            end
        end
        rdy_prev = app_rdy;
    end

    // response back-pressure
    always @(posedge clk_if) begin
        logic a;
        logic b;
        a          = lfsr_ready[0];
        lfsr_ready = galois_step(lfsr_ready);
        b          = lfsr_ready[0];
        lfsr_ready = galois_step(lfsr_ready);
        a          = (a | b) && !hold_ready;
        #1;
        rd_resp_ready = a;
    end

    initial begin
        ram_cmd_t c;
        lfsr_stim     = 32'h87ee_436e;
        lfsr_ready    = 32'h87ee_436e;
        resetn        = 1'b0;
        cmd           = '0;
        cmd_valid     = 1'b0;
        rd_resp_ready = 1'b0;
        hold_ready    = 1'b0;
        any_cmd       = 1'b0;
        rdy_prev      = 1'b0;
        repeat (10) @(posedge clk_if);
        #1;
        resetn = 1'b1;
        for (int i = 0; i < LINES; i++) begin
            shadow[i] = mem_model.mem[i];
        end
        // quiet after reset, nothing may move
        idle(8);

        // partial write at an offset, then read back the whole line
        c      = random_cmd(1'b0);
        c.addr = 29'h35;
        c.strb = 16'h0f0f;
        send_cmd(c);
        c      = random_cmd(1'b1);
        c.addr = 29'h30;
        send_cmd(c);

        for (int i = 0; i < 80; i++) begin
            send_cmd(random_cmd(1'(rand_bits(1))));
            if (rand_bits(2) == 0) begin
                idle(int'(rand_bits(3)));
            end
        end
        wait_drain();

        // queue fills, then one read parks in decode
        hold_ready = 1'b1;
        for (int i = 0; i < RESP_DEPTH + 1; i++) begin
            send_cmd(random_cmd(1'b1));
        end
        wait_ready_held_low(20);
        // only the parked read may still be waiting for its issue
        check_value("app commands outstanding", app_exp_q.size(), 1);
        check_value("rd_resp_valid while held", rd_resp_valid, 1'b1);
        hold_ready = 1'b0;

        for (int i = 0; i < 20; i++) begin
            send_cmd(random_cmd(1'(rand_bits(1))));
        end
        wait_drain();
        check_value("rd_resp_valid after drain", rd_resp_valid, 1'b0);
        check_value("cmd_ready after drain", cmd_ready, 1'b1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
